// ==== hdl/arrayAllocator.sv ====
//--------------------
// Array allocator
// Allocation marks, high-water count and freed-number stack
//--------------------
`timescale 1ns/10ps

module arrayAllocator (
  input  logic                clock,
  input  logic                resetN,
  input  heapPkg::heapCommand command,
  input  heapPkg::arrayT      queryArray,
  output logic                allocated,
  output logic                everUsed,
  output logic                full,
  output heapPkg::arrayT      newArray
);

  logic [heapPkg::arrayCount-1:0] marks;                // One bit per live array
  heapPkg::countT                 highWater;            // Numbers ever handed out
  heapPkg::countT                 stackTop;             // Freed numbers on the stack
  heapPkg::countT                 stackBelow;
  heapPkg::arrayT                 freeStack [heapPkg::arrayCount];

  assign stackBelow = stackTop - 1'b1;

  // Freed numbers come first in LIFO order
  assign newArray  = (stackTop != '0) ? freeStack[stackBelow[heapPkg::addressBits-1:0]]
                                      : highWater[heapPkg::addressBits-1:0];
  assign allocated = marks[queryArray];
  assign everUsed  = heapPkg::countT'(queryArray) < highWater;
  assign full      = (stackTop == '0) &&
                     (highWater == heapPkg::countT'(heapPkg::arrayCount));

  // --------------------
  // Control state
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      marks     <= '0;
      highWater <= '0;
      stackTop  <= '0;
    end else begin
      case (command.action)
        heapPkg::Reset: begin
          marks     <= '0;                              // Same as the reset pin
          highWater <= '0;
          stackTop  <= '0;
        end
        heapPkg::Alloc: begin
          marks[newArray] <= 1'b1;
          if (stackTop != '0) stackTop  <= stackBelow;
          else                highWater <= highWater + 1'b1;
        end
        heapPkg::Free: begin
          marks[command.array] <= 1'b0;
          stackTop             <= stackTop + 1'b1;
        end
        default: ;
      endcase
    end
  end

  // Stack never overflows since a number is freed at most once
  always_ff @(posedge clock) begin
    if (command.action == heapPkg::Free) begin
      freeStack[stackTop[heapPkg::addressBits-1:0]] <= command.array;
    end
  end

endmodule

// ==== hdl/elementAlu.sv ====
//--------------------
// Element arithmetic
// New value of an element for the in-place actions
//--------------------
`timescale 1ns/10ps

module elementAlu (
  input  heapPkg::actionT action,
  input  heapPkg::dataT   element,                  // Current stored value
  input  heapPkg::dataT   operand,                  // Request data
  output heapPkg::dataT   result
);

  always_comb begin
    case (action)
      heapPkg::Add, heapPkg::AddAfter: begin
        result = element + operand;
      end
      heapPkg::Subtract, heapPkg::SubAfter: begin
        result = element - operand;
      end
      heapPkg::ShiftLeft:  result = element << operand;   // Operand is the count
      heapPkg::ShiftRight: result = element >> operand;
      heapPkg::NotLogical: begin
        result = heapPkg::dataT'(element == '0);          // One only for zero
      end
      heapPkg::Not:        result = ~element;
      heapPkg::Or:         result = element | operand;
      heapPkg::Xor:        result = element ^ operand;
      heapPkg::And:        result = element & operand;
      default:             result = element;              // Not stored for others
    endcase
  end

endmodule

// ==== hdl/elementStore.sv ====
//--------------------
// Element store
// Element memory, array sizes and the data output
//--------------------
`timescale 1ns/10ps

module elementStore (
  input  logic                clock,
  input  logic                resetN,
  input  heapPkg::heapCommand command,
  input  heapPkg::arrayT      newArray,             // Array the next Alloc gets
  input  heapPkg::arrayT      queryArray,
  output heapPkg::sizeT       arraySize,
  output heapPkg::dataT       readData
);

  heapPkg::dataT  memory [heapPkg::arrayCount][heapPkg::arrayLength];
  heapPkg::sizeT  sizes  [heapPkg::arrayCount];
  heapPkg::sizeT  currentSize;                          // Size of command array
  heapPkg::indexT pushIndex;
  heapPkg::indexT popIndex;
  heapPkg::dataT  element;                              // Element at command index
  heapPkg::dataT  aluResult;

  assign arraySize   = sizes[queryArray];
  assign currentSize = sizes[command.array];
  assign pushIndex   = currentSize[heapPkg::indexBits-1:0];
  assign popIndex    = heapPkg::indexT'(currentSize - 1'b1);
  assign element     = memory[command.array][command.index];

  elementAlu alu0 (
    .action  (command.action),
    .element (element),
    .operand (command.data),
    .result  (aluResult)
  );

  // --------------------
  // Memory write
  // --------------------
  always_ff @(posedge clock) begin
    case (command.action)
      heapPkg::Write: memory[command.array][command.index] <= command.data;
      heapPkg::Push:  memory[command.array][pushIndex]     <= command.data;
      heapPkg::Add, heapPkg::AddAfter, heapPkg::Subtract, heapPkg::SubAfter,
      heapPkg::ShiftLeft, heapPkg::ShiftRight, heapPkg::NotLogical,
      heapPkg::Not, heapPkg::Or, heapPkg::Xor, heapPkg::And: begin
        memory[command.array][command.index] <= aluResult;   // In place
      end
      default: ;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      sizes <= '{default: '0};
    end else begin
      case (command.action)
        heapPkg::Write: begin
          if (heapPkg::sizeT'(command.index) >= currentSize) begin
            sizes[command.array] <= heapPkg::sizeT'(command.index) + 1'b1;   // Grow
          end
        end
        heapPkg::Push:  sizes[command.array] <= currentSize + 1'b1;
        heapPkg::Pop:   sizes[command.array] <= currentSize - 1'b1;
        heapPkg::Alloc: sizes[newArray]      <= '0;     // Fresh array starts empty
        default: ;
      endcase
    end
  end

  // --------------------
  // Data output
  // --------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      readData <= '0;
    end else begin
      case (command.action)
        heapPkg::Write:    readData <= command.data;
        heapPkg::Read:     readData <= element;
        heapPkg::Size:     readData <= heapPkg::dataT'(currentSize);
        heapPkg::Pop:      readData <= memory[command.array][popIndex];
        heapPkg::Alloc:    readData <= heapPkg::dataT'(newArray);
        heapPkg::AddAfter, heapPkg::SubAfter: readData <= element;   // Previous value
        heapPkg::Add, heapPkg::Subtract, heapPkg::ShiftLeft, heapPkg::ShiftRight,
        heapPkg::NotLogical, heapPkg::Not, heapPkg::Or, heapPkg::Xor,
        heapPkg::And: readData <= aluResult;
        default: ;                                      // Idle, Push, Free, Reset hold
      endcase
    end
  end

endmodule

// ==== hdl/heapMemory.sv ====
//--------------------
// Heap top level
// Decoder, allocator and element store
//--------------------
`timescale 1ns/10ps

module heapMemory (
  input  logic               clock,
  input  logic               resetN,
  input  heapPkg::heapRequest request,
  output heapPkg::dataT      readData,
  output heapPkg::errorT     error
);

  heapPkg::heapCommand command;                         // Checked request
  heapPkg::arrayT      newArray;                        // Number for next Alloc
  heapPkg::sizeT       arraySize;                       // Size of requested array
  logic                allocated;
  logic                everUsed;
  logic                full;

  requestDecoder decoder0 (
    .clock     (clock),
    .resetN    (resetN),
    .request   (request),
    .allocated (allocated),
    .everUsed  (everUsed),
    .full      (full),
    .arraySize (arraySize),
    .command   (command),
    .error     (error)
  );

  arrayAllocator allocator0 (
    .clock      (clock),
    .resetN     (resetN),
    .command    (command),
    .queryArray (request.array),
    .allocated  (allocated),
    .everUsed   (everUsed),
    .full       (full),
    .newArray   (newArray)
  );

  elementStore store0 (
    .clock      (clock),
    .resetN     (resetN),
    .command    (command),
    .newArray   (newArray),
    .queryArray (request.array),
    .arraySize  (arraySize),
    .readData   (readData)
  );

endmodule

// ==== hdl/heapPkg.sv ====
//--------------------
// Heap sizes and the derived vector types
// Action codes, error codes, request and command structs
//--------------------
package heapPkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int addressBits = 3;                       // Bits of an array number
  localparam int indexBits   = 3;                       // Bits of an element index
  localparam int dataBits    = 16;                      // Element width
  localparam int arrayCount  = 2 ** addressBits;        // Arrays in the heap
  localparam int arrayLength = 2 ** indexBits;          // Elements per array
  localparam int countBits   = addressBits + 1;         // Holds 0 to arrayCount

  typedef logic [addressBits-1:0] arrayT;
  typedef logic [indexBits-1:0]   indexT;
  typedef logic [dataBits-1:0]    dataT;
  typedef logic [indexBits:0]     sizeT;                // Up to arrayLength inclusive
  typedef logic [countBits-1:0]   countT;               // Array numbers handed out

  // --------------------
  // Actions
  // --------------------
  // Codes outside this list act as Idle
  typedef enum logic [7:0] {
    Idle       = 8'd0,
    Reset      = 8'd1,                                  // Forget every array
    Write      = 8'd2,
    Read       = 8'd3,
    Size       = 8'd4,
    Push       = 8'd14,
    Pop        = 8'd15,
    Alloc      = 8'd18,
    Free       = 8'd19,
    Add        = 8'd20,                                 // Returns new value
    AddAfter   = 8'd21,                                 // Returns previous value
    Subtract   = 8'd22,
    SubAfter   = 8'd23,
    ShiftLeft  = 8'd24,
    ShiftRight = 8'd25,
    NotLogical = 8'd26,
    Not        = 8'd27,
    Or         = 8'd28,
    Xor        = 8'd29,
    And        = 8'd30
  } actionT;

  typedef enum logic [2:0] {
    none,
    notAllocated,                                       // Array never handed out
    freed,                                              // Array freed since
    outOfBounds,                                        // Index at or past size
    empty,                                              // Pop of empty array
    full,                                               // Push to full array
    outOfMemory                                         // No array left for Alloc
  } errorT;

  // --------------------
  // Bus structs
  // --------------------
  typedef struct packed {
    actionT action;
    arrayT  array;
    indexT  index;
    dataT   data;
  } heapRequest;

  // Same layout for requests that passed every check
  typedef struct packed {
    actionT action;
    arrayT  array;
    indexT  index;
    dataT   data;
  } heapCommand;

endpackage

// ==== hdl/requestDecoder.sv ====
//--------------------
// Request decoder
// Checks every access rule and holds the error register
//--------------------
`timescale 1ns/10ps

module requestDecoder (
  input  logic                clock,
  input  logic                resetN,
  input  heapPkg::heapRequest request,
  input  logic                allocated,            // Requested array is live
  input  logic                everUsed,             // Requested array was handed out
  input  logic                full,                 // No array left for Alloc
  input  heapPkg::sizeT       arraySize,            // Size of requested array
  output heapPkg::heapCommand command,
  output heapPkg::errorT      error
);

  heapPkg::errorT accessError;                          // Allocation check alone
  heapPkg::errorT checkError;                           // Full verdict for this request
  logic           known;                                // Action is not Idle or unknown
  logic           beyondSize;

  // --------------------
  // Access checks
  // --------------------
  always_comb begin
    if (!everUsed) begin
      accessError = heapPkg::notAllocated;
    end else if (!allocated) begin
      accessError = heapPkg::freed;                     // Also catches a double free
    end else begin
      accessError = heapPkg::none;
    end
  end

  assign beyondSize = heapPkg::sizeT'(request.index) >= arraySize;

  always_comb begin
    known      = 1'b1;
    checkError = heapPkg::none;
    case (request.action)
      heapPkg::Reset: begin
        checkError = heapPkg::none;
      end
      heapPkg::Alloc: begin
        if (full) checkError = heapPkg::outOfMemory;
      end
      heapPkg::Write, heapPkg::Size, heapPkg::Free: begin
        checkError = accessError;                       // Write may grow the array
      end
      heapPkg::Read, heapPkg::Add, heapPkg::AddAfter, heapPkg::Subtract,
      heapPkg::SubAfter, heapPkg::ShiftLeft, heapPkg::ShiftRight,
      heapPkg::NotLogical, heapPkg::Not, heapPkg::Or, heapPkg::Xor,
      heapPkg::And: begin
        if (accessError != heapPkg::none) checkError = accessError;
        else if (beyondSize)              checkError = heapPkg::outOfBounds;
      end
      heapPkg::Push: begin
        if (accessError != heapPkg::none) checkError = accessError;
        else if (arraySize == heapPkg::sizeT'(heapPkg::arrayLength)) begin
          checkError = heapPkg::full;
        end
      end
      heapPkg::Pop: begin
        if (accessError != heapPkg::none) checkError = accessError;
        else if (arraySize == '0)         checkError = heapPkg::empty;
      end
      default: known = 1'b0;                            // Idle and unused codes
    endcase
  end

  // --------------------
  // Command out
  // --------------------
  always_comb begin
    command.array  = request.array;
    command.index  = request.index;
    command.data   = request.data;
    command.action = request.action;
    if (!known || checkError != heapPkg::none) command.action = heapPkg::Idle;
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      error <= heapPkg::none;
    end else if (known) begin
      error <= checkError;                              // Held through Idle
    end
  end

endmodule

// ==== project.f ====
+incdir+tb
hdl/heapPkg.sv
hdl/elementAlu.sv
hdl/elementStore.sv
hdl/arrayAllocator.sv
hdl/requestDecoder.sv
hdl/heapMemory.sv
tb/heapMemoryTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the heap testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module heapMemoryTb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VheapMemoryTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
exit 0

// ==== tb/heapModel.svh ====
//--------------------
// Behavioral heap model
// Mirror of arrays, sizes and elements, element rule, per-request update
//--------------------
`ifndef heapModelSvh
`define heapModelSvh

  bit             modelMark  [heapPkg::arrayCount];     // Array is live
  int             modelHigh;                            // Numbers ever handed out
  int             modelStack [$];                       // Freed numbers with the last on top
  int             modelSize  [heapPkg::arrayCount];
  heapPkg::dataT  modelMem   [heapPkg::arrayCount][heapPkg::arrayLength];
  bit             modelKnown [heapPkg::arrayCount][heapPkg::arrayLength];  // Ever written
  heapPkg::dataT  expData;
  bit             expDataKnown;                         // Data defined by the model
  heapPkg::errorT expError;

  // New element value for the in-place actions
  function automatic heapPkg::dataT elementRule(heapPkg::actionT action, heapPkg::dataT a,
                                                heapPkg::dataT b);
    case (action)
      heapPkg::Add, heapPkg::AddAfter:      return a + b;
      heapPkg::Subtract, heapPkg::SubAfter: return a - b;
      heapPkg::ShiftLeft:  return (b > 16'd15) ? 16'h0000 : a << b;
      heapPkg::ShiftRight: return (b > 16'd15) ? 16'h0000 : a >> b;
      heapPkg::NotLogical: return (a == 16'h0000) ? 16'h0001 : 16'h0000;
      heapPkg::Not:        return ~a;
      heapPkg::Or:         return a | b;
      heapPkg::Xor:        return a ^ b;
      heapPkg::And:        return a & b;
      default:             return a;
    endcase
  endfunction

  task automatic clearAllocations();
    for (int n = 0; n < heapPkg::arrayCount; n++) begin
      modelMark[n] = 1'b0;
    end
    modelHigh = 0;
    modelStack.delete();
  endtask

  // --------------------
  // One request
  // --------------------
  task automatic applyModel(heapPkg::heapRequest r);
    heapPkg::errorT access;
    heapPkg::dataT  old;
    int             a;
    int             i;
    a = int'(r.array);
    i = int'(r.index);
    if (a >= modelHigh) access = heapPkg::notAllocated;
    else if (!modelMark[a]) access = heapPkg::freed;
    else access = heapPkg::none;
    case (r.action)
      heapPkg::Reset: begin
        clearAllocations();
        expError = heapPkg::none;
      end
      heapPkg::Alloc: begin
        if (modelStack.size() == 0 && modelHigh == heapPkg::arrayCount) begin
          expError = heapPkg::outOfMemory;
        end else begin
          if (modelStack.size() != 0) begin
            a = modelStack.pop_back();                  // Last freed first
          end else begin
            a = modelHigh;
            modelHigh++;
          end
          modelMark[a] = 1'b1;
          modelSize[a] = 0;
          expData      = heapPkg::dataT'(a);
          expDataKnown = 1'b1;
          expError     = heapPkg::none;
        end
      end
      heapPkg::Free: begin
        expError = access;
        if (access == heapPkg::none) begin
          modelMark[a] = 1'b0;
          modelStack.push_back(a);
        end
      end
      heapPkg::Write: begin
        expError = access;
        if (access == heapPkg::none) begin
          modelMem[a][i]   = r.data;
          modelKnown[a][i] = 1'b1;
          if (i >= modelSize[a]) modelSize[a] = i + 1;  // Grows the array
          expData      = r.data;
          expDataKnown = 1'b1;
        end
      end
      heapPkg::Size: begin
        expError = access;
        if (access == heapPkg::none) begin
          expData      = heapPkg::dataT'(modelSize[a]);
          expDataKnown = 1'b1;
        end
      end
      heapPkg::Push: begin
        if (access != heapPkg::none) expError = access;
        else if (modelSize[a] == heapPkg::arrayLength) expError = heapPkg::full;
        else begin
          expError                    = heapPkg::none;
          modelMem[a][modelSize[a]]   = r.data;
          modelKnown[a][modelSize[a]] = 1'b1;
          modelSize[a]++;
        end
      end
      heapPkg::Pop: begin
        if (access != heapPkg::none) expError = access;
        else if (modelSize[a] == 0) expError = heapPkg::empty;
        else begin
          expError = heapPkg::none;
          modelSize[a]--;
          expData      = modelMem[a][modelSize[a]];
          expDataKnown = modelKnown[a][modelSize[a]];
        end
      end
      heapPkg::Read, heapPkg::Add, heapPkg::AddAfter, heapPkg::Subtract,
      heapPkg::SubAfter, heapPkg::ShiftLeft, heapPkg::ShiftRight,
      heapPkg::NotLogical, heapPkg::Not, heapPkg::Or, heapPkg::Xor, heapPkg::And: begin
        if (access != heapPkg::none) expError = access;
        else if (i >= modelSize[a]) expError = heapPkg::outOfBounds;
        else begin
          expError     = heapPkg::none;
          old          = modelMem[a][i];
          expDataKnown = modelKnown[a][i];
          if (r.action != heapPkg::Read) modelMem[a][i] = elementRule(r.action, old, r.data);
          if (r.action inside {heapPkg::Read, heapPkg::AddAfter, heapPkg::SubAfter}) begin
            expData = old;                              // Value before the update
          end else begin
            expData = modelMem[a][i];
          end
        end
      end
      default: ;                                        // Idle holds both outputs
    endcase
  endtask

`endif

// ==== tb/heapMemoryTb.sv ====
//--------------------
// Heap testbench
// Clock, reset, directed and random requests, checks and closing report
//--------------------
`timescale 1ns/10ps

module heapMemoryTb;

  logic                clock;
  logic                resetN;
  heapPkg::heapRequest request;
  heapPkg::dataT       readData;
  heapPkg::errorT      error;

  heapPkg::heapRequest pending;                         // Sampled by the DUT next edge
  logic [31:0]         lfsrState;
  int                  checks;
  int                  dataErrors;
  int                  codeErrors;
  int                  timeouts;

  `include "heapModel.svh"

  heapMemory dut0 (
    .clock    (clock),
    .resetN   (resetN),
    .request  (request),
    .readData (readData),
    .error    (error)
  );

  initial clock = 1'b0;
  always #2 clock = ~clock;                             // 4 ns period

  // --------------------
  // Random numbers
  // --------------------
  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] randomBits(int count);
    logic [31:0] value;
    value = '0;
    for (int b = 0; b < count; b++) begin
      lfsrState = lfsrNext(lfsrState);
      value     = {value[30:0], lfsrState[0]};          // One step per bit
    end
    return value;
  endfunction

  function automatic logic [7:0] pickAction(int round);
    logic [4:0] roll;
    logic [7:0] pick;
    roll = randomBits(5);
    if (round < 64 && roll < 5'd12) begin               // Fill the heap early
      case (roll % 3)
        0:       pick = heapPkg::Alloc;
        1:       pick = heapPkg::Write;
        default: pick = heapPkg::Push;
      endcase
    end else begin
      case (roll)
        0, 1, 2, 30: pick = heapPkg::Write;
        3, 4, 31:    pick = heapPkg::Read;
        5:           pick = heapPkg::Size;
        6, 7, 8:     pick = heapPkg::Push;
        9, 10:       pick = heapPkg::Pop;
        11, 12, 13:  pick = heapPkg::Alloc;
        14, 15:      pick = heapPkg::Free;
        27:          pick = heapPkg::Idle;
        28:          pick = 8'd5;                       // Unused code
        29:          pick = heapPkg::Reset;
        default:     pick = 8'(roll) + 8'd4;            // Add through And
      endcase
    end
    return pick;
  endfunction

  // --------------------
  // Drive and check
  // --------------------
  task automatic compareOutputs();
    checks++;
    assert (error === expError) else begin
      codeErrors++;
      $display("Error: error = 0x%h, expected 0x%h at %0t", error, expError, $time);
    end
    if (expDataKnown) begin
      assert (readData === expData) else begin
        dataErrors++;
        $display("Error: readData = 0x%h, expected 0x%h at %0t", readData, expData, $time);
      end
    end
  endtask

  task automatic step(logic [7:0] action, int array, int index, int data);
    heapPkg::heapRequest next;
    next.action = heapPkg::actionT'(action);
    next.array  = heapPkg::arrayT'(array);
    next.index  = heapPkg::indexT'(index);
    next.data   = heapPkg::dataT'(data);
    @(posedge clock);
    request <= next;
    applyModel(pending);                                // DUT takes it at this edge
    pending = next;
    @(negedge clock);
    compareOutputs();
  endtask

  task automatic waitForResetState(output bit ready);
    int cycles;
    ready  = 1'b0;
    cycles = 0;
    while (!ready && cycles < 10) begin
      @(negedge clock);
      ready = (error === heapPkg::none) && (readData === 16'h0000);
      cycles++;
    end
  endtask

  task automatic directedTests();
    step(heapPkg::Read, 2, 0, 0);                       // Never allocated
    for (int n = 0; n <= heapPkg::arrayCount; n++) begin
      step(heapPkg::Alloc, 0, 0, 0);                    // Last one runs out
    end
    step(heapPkg::Free, 3, 0, 0);
    step(heapPkg::Free, 5, 0, 0);
    step(heapPkg::Free, 5, 0, 0);                       // Double free
    step(heapPkg::Write, 5, 0, 16'h1234);
    step(heapPkg::Alloc, 0, 0, 0);
    step(heapPkg::Alloc, 0, 0, 0);
    step(heapPkg::Write, 0, 2, 16'hbeef);
    step(heapPkg::Read, 0, 2, 0);
    step(heapPkg::Size, 0, 0, 0);
    step(heapPkg::Read, 0, 3, 0);                       // Past the end
    step(heapPkg::Write, 0, 0, 16'h0005);
    for (int n = 0; n <= heapPkg::arrayLength; n++) begin
      step(heapPkg::Push, 1, 0, 16'h0100 + n);
    end
    for (int n = 0; n <= heapPkg::arrayLength; n++) begin
      step(heapPkg::Pop, 1, 0, 0);
    end
    for (int code = heapPkg::Add; code <= heapPkg::And; code++) begin
      step(8'(code), 0, 2, int'(randomBits(4)));
      step(heapPkg::Read, 0, 2, 0);
    end
    step(heapPkg::Reset, 0, 0, 0);
    step(heapPkg::Alloc, 0, 0, 0);
    step(heapPkg::Read, 3, 0, 0);
  endtask

  task automatic randomTests(int rounds);
    logic [7:0] action;
    int         array;
    int         index;
    int         data;
    for (int round = 0; round < rounds; round++) begin
      action = pickAction(round);
      array  = int'(randomBits(3));
      index  = int'(randomBits(3));
      if (action == heapPkg::ShiftLeft || action == heapPkg::ShiftRight) begin
        data = int'(randomBits(5));
      end else begin
        data = int'(randomBits(16));
      end
      step(action, array, index, data);
    end
    step(heapPkg::Idle, 0, 0, 0);                       // Check the last request
  endtask

  task automatic finishRun();
    $display("Checks %0d, readData errors %0d, error code errors %0d, timeouts %0d",
             checks, dataErrors, codeErrors, timeouts);
    if (dataErrors + codeErrors + timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    bit ready;
    resetN       = 1'b0;
    request      = '0;
    pending      = '0;
    lfsrState    = 32'd85270;
    checks       = 0;
    dataErrors   = 0;
    codeErrors   = 0;
    timeouts     = 0;
    expData      = '0;
    expDataKnown = 1'b1;
    expError     = heapPkg::none;
    clearAllocations();
    repeat (5) @(posedge clock);
    resetN <= 1'b1;
    waitForResetState(ready);
    if (!ready) begin
      timeouts++;
      $display("Timeout: outputs did not reach their reset values");
    end else begin
      directedTests();
      randomTests(400);
    end
    finishRun();
  end

endmodule
